/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_top.sv */
`timescale 1ns/1ps

module tb_top import acq_pkg::*; ();

    localparam int     CLK_NS    = 20;
    localparam int     RST_CYC   = 8;
    localparam int     RUNS      = 24;
    localparam int     MAX_BYTES = 1 + 2 * N_CH;
    localparam int     RUN_CYC   = 2 * (MAX_BYTES * 10 * BIT_DIV + SPI_BITS * SCLK_DIV);
    localparam longint WDOG_NS   = longint'(RUNS) * RUN_CYC * CLK_NS;

    logic            clk;
    logic            rst_n;
    logic            start;
    logic [N_CH-1:0] chan_mask;
    logic [N_CH-1:0] adc_miso;
    logic            adc_mosi;
    logic            adc_sclk;
    logic [N_CH-1:0] adc_cs;
    logic            com_rxf;
    logic            com_txd;
    logic            com_txf;
    logic            busy;
    logic            done;

    integer              seed;
    int                  mismatches;
    int                  failures;
    int                  rx_errs;
    int                  done_cnt;
    logic                hold_rxf;
    logic [N_CH-1:0]     cs_seen;
    logic                txf_low;
    logic                txf_val;
    int                  gap_tab [16];
    logic [SAMPLE_W-1:0] adc_val [N_CH];
    logic [SPI_BITS-1:0] miso_sr [N_CH];
    logic [SPI_BITS-1:0] mosi_cap [N_CH];
    logic [7:0]          rx_q [$];
    logic [7:0]          exp_q [$];

    top UUT (
        .clk(clk),
        .rst_n(rst_n),
        .start(start),
        .chan_mask(chan_mask),
        .adc_miso(adc_miso),
        .adc_mosi(adc_mosi),
        .adc_sclk(adc_sclk),
        .adc_cs(adc_cs),
        .com_rxf(com_rxf),
        .com_txd(com_txd),
        .com_txf(com_txf),
        .busy(busy),
        .done(done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_NS / 2) clk = ~clk;
        end
    end

    // ------------------------------------------------------------
    // ADC slaves shift MSB first after each falling SCLK.
    // ------------------------------------------------------------
    initial begin : adc_slaves
        logic [N_CH-1:0] cs_q;
        logic            sclk_q;
        cs_q     = '1;
        sclk_q   = 1'b0;
        adc_miso = '0;
        for (int i = 0; i < N_CH; i++) begin
            miso_sr[i]  = '0;
            mosi_cap[i] = '0;
        end
        forever begin
            @(negedge clk);
            for (int i = 0; i < N_CH; i++) begin
                if (!adc_cs[i]) begin
                    if (cs_q[i]) begin
                        miso_sr[i]  = {{(SPI_BITS - SAMPLE_W){1'b0}}, adc_val[i]};
                        mosi_cap[i] = '0;
                    end else if (sclk_q && !adc_sclk) begin
                        miso_sr[i] = miso_sr[i] << 1;
                    end
                    if (!sclk_q && adc_sclk) begin
                        mosi_cap[i] = {mosi_cap[i][SPI_BITS-2:0], adc_mosi};
                    end
                end
                adc_miso[i] = miso_sr[i][SPI_BITS-1];
            end
            cs_q   = adc_cs;
            sclk_q = adc_sclk;
        end
    end

    // ------------------------------------------------------------
    // Serial receiver sampling mid-bit with random flow gaps.
    // ------------------------------------------------------------
    initial begin : uart_rx
        logic [7:0] b;
        int         gap;
        b       = '0;
        gap     = 0;
        com_rxf = 1'b0;
        forever begin
            @(negedge clk);
            if (hold_rxf) begin
                com_rxf = 1'b1;
            end else if (gap > 0) begin
                com_rxf = 1'b1;
                gap--;
            end else begin
                com_rxf = 1'b0;
            end
            if (rst_n && !com_txd) begin
                repeat (BIT_DIV / 2) @(negedge clk);
                if (com_txd) begin
                    rx_errs++;
                    $display("ERROR at %0t: start bit on com_txd shorter than half a bit", $time);
                end
                for (int k = 0; k < 8; k++) begin
                    repeat (BIT_DIV) @(negedge clk);
                    b[k] = com_txd;
                end
                repeat (BIT_DIV) @(negedge clk);
                if (!com_txd) begin
                    rx_errs++;
                    $display("ERROR at %0t: stop bit on com_txd is low", $time);
                end
                rx_q.push_back(b);
                gap = gap_tab[rx_q.size() % 16];
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        mismatches++;
        $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
    endtask

    task automatic note_failure(input string msg);
        failures++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // One cycle of CS, done and com_txf tracking.
    task automatic step();
        @(negedge clk);
        cs_seen = cs_seen | ~adc_cs;
        if (done) begin
            done_cnt++;
        end
        if (com_txd === 1'b0 && com_txf !== 1'b1 && !txf_low) begin
            txf_low = 1'b1;
            txf_val = com_txf;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    task automatic pulse_start(input logic [N_CH-1:0] m);
        chan_mask = m;
        start     = 1'b1;
        step();
        start     = 1'b0;
    endtask

    function automatic logic [N_CH-1:0] rand_mask();
        logic [31:0]     r;
        logic [N_CH-1:0] m;
        m = '0;
        while (m == '0) begin
            r = $random(seed);
            m = r[N_CH-1:0];
        end
        return m;
    endfunction

    // Expected frame is the header then two bytes per enabled channel.
    function automatic void build_frame(input logic [N_CH-1:0] m);
        exp_q.delete();
        exp_q.push_back({HDR_TAG, m});
        for (int i = 0; i < N_CH; i++) begin
            if (m[i]) begin
                exp_q.push_back({i[CH_W-1:0], 2'b00, adc_val[i][SAMPLE_W-1:8]});
                exp_q.push_back(adc_val[i][7:0]);
            end
        end
    endfunction

    // ------------------------------------------------------------
    // One acquisition run checked against the frame model.
    // ------------------------------------------------------------
    task automatic run_frame(input string name, input logic [N_CH-1:0] m,
                             input bit poke_busy, input int hold_cycles);
        logic [31:0] r;
        int          base;
        int          n;
        bit          txd_bad;
        for (int i = 0; i < N_CH; i++) begin
            r = $random(seed);
            adc_val[i] = r[SAMPLE_W-1:0];
        end
        build_frame(m);
        base     = rx_q.size();
        cs_seen  = '0;
        done_cnt = 0;
        txf_low  = 1'b0;
        txd_bad  = 1'b0;
        if (hold_cycles > 0) begin
            hold_rxf = 1'b1;
            idle(2);
        end
        pulse_start(m);
        if (busy !== 1'b1) begin
            note_failure($sformatf("%s: busy did not rise after start", name));
        end
        if (poke_busy) begin
            idle(10);
            pulse_start(4'hf);
            idle(150);
            pulse_start(4'hf);
        end
        if (hold_cycles > 0) begin
            for (int c = 0; c < hold_cycles; c++) begin
                step();
                if (com_txd !== 1'b1 || com_txf !== 1'b0) begin
                    txd_bad = 1'b1;
                end
            end
            if (txd_bad) begin
                note_failure($sformatf("%s: byte sent while com_rxf was high", name));
            end
            hold_rxf = 1'b0;
        end
        n = 0;
        while (done_cnt == 0 && n < RUN_CYC) begin
            step();
            n++;
        end
        if (done_cnt == 0) begin
            note_failure($sformatf("%s: timeout waiting for done", name));
        end
        idle(poke_busy ? 200 : 4);
        if (rx_q.size() - base != exp_q.size()) begin
            report_mismatch($sformatf("%s frame length", name), 32'(exp_q.size()),
                            32'(rx_q.size() - base));
        end else begin
            for (int k = 0; k < exp_q.size(); k++) begin
                if (rx_q[base + k] !== exp_q[k]) begin
                    report_mismatch($sformatf("%s byte %0d", name, k), 32'(exp_q[k]),
                                    32'(rx_q[base + k]));
                end
            end
        end
        if (cs_seen !== m) begin
            report_mismatch($sformatf("%s adc_cs", name), 32'(m), 32'(cs_seen));
        end
        for (int i = 0; i < N_CH; i++) begin
            if (m[i] && mosi_cap[i] !== ADC_CMD) begin
                report_mismatch($sformatf("%s mosi ch%0d", name, i), 32'(ADC_CMD),
                                32'(mosi_cap[i]));
            end
        end
        if (txf_low) begin
            report_mismatch($sformatf("%s com_txf during byte", name), 32'h1,
                            32'(txf_val));
        end
        if (com_txf !== 1'b0) begin
            report_mismatch($sformatf("%s com_txf after done", name), 32'h0,
                            32'(com_txf));
        end
        if (done_cnt != 1) begin
            report_mismatch($sformatf("%s done pulses", name), 32'd1, 32'(done_cnt));
        end
        if (busy !== 1'b0) begin
            note_failure($sformatf("%s: busy still high after done", name));
        end
    endtask

    task automatic zero_mask_start();
        int base;
        base     = rx_q.size();
        cs_seen  = '0;
        done_cnt = 0;
        pulse_start('0);
        if (busy !== 1'b0) begin
            note_failure("zero_mask: start with mask 0 raised busy");
        end
        idle(2 * SPI_BITS * SCLK_DIV);
        if (cs_seen !== '0) begin
            report_mismatch("zero_mask adc_cs", 32'h0, 32'(cs_seen));
        end
        if (rx_q.size() != base) begin
            report_mismatch("zero_mask bytes", 32'h0, 32'(rx_q.size() - base));
        end
        if (done_cnt != 0) begin
            report_mismatch("zero_mask done pulses", 32'h0, 32'(done_cnt));
        end
    endtask

    initial begin : watchdog
        #(WDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    initial begin : main
        logic [31:0] r;
        seed       = 32'h1ef4d60f;
        mismatches = 0;
        failures   = 0;
        rx_errs    = 0;
        done_cnt   = 0;
        cs_seen    = '0;
        txf_low    = 1'b0;
        txf_val    = 1'b0;
        hold_rxf   = 1'b0;
        rst_n      = 1'b0;
        start      = 1'b0;
        chan_mask  = '0;
        for (int i = 0; i < N_CH; i++) begin
            adc_val[i] = '0;
        end
        for (int k = 0; k < 16; k++) begin
            r = $random(seed);
            gap_tab[k] = int'(r & 32'h7);
        end
        repeat (RST_CYC) @(negedge clk);
        rst_n = 1'b1;
        step();

        // Idle outputs right after reset.
        if (busy !== 1'b0) begin
            report_mismatch("reset busy", 32'h0, 32'(busy));
        end
        if (done !== 1'b0) begin
            report_mismatch("reset done", 32'h0, 32'(done));
        end
        if (com_txf !== 1'b0) begin
            report_mismatch("reset com_txf", 32'h0, 32'(com_txf));
        end
        if (adc_sclk !== 1'b0) begin
            report_mismatch("reset adc_sclk", 32'h0, 32'(adc_sclk));
        end
        if (adc_cs !== '1) begin
            report_mismatch("reset adc_cs", 32'hf, 32'(adc_cs));
        end
        if (com_txd !== 1'b1) begin
            report_mismatch("reset com_txd", 32'h1, 32'(com_txd));
        end

        run_frame("full_capture", 4'hf, 1'b0, 0);
        for (int n = 0; n < 20; n++) begin
            run_frame($sformatf("partial_%0d", n), rand_mask(), 1'b0, 0);
        end
        zero_mask_start();
        run_frame("start_while_busy", 4'h5, 1'b1, 0);
        run_frame("flow_control", 4'hb, 1'b0, 300);

        $display("Summary: %0d mismatches, %0d other errors", mismatches,
                 failures + rx_errs);
        if (mismatches + failures + rx_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* dv/top_chk.sv */
`timescale 1ns/1ps

module top_chk import acq_pkg::*; (
    input logic            clk,
    input logic            rst_n,
    input logic [N_CH-1:0] adc_cs,
    input logic            adc_sclk,
    input logic            com_txd,
    input logic            busy,
    input logic            done
);

    // SCLK idles low between transfers.
    sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (&adc_cs) |-> !adc_sclk)
        else $error("adc_sclk high while every adc_cs is high");

    // Serial line stays idle outside a run.
    txd_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> com_txd)
        else $error("com_txd low while busy is low");

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done held for more than one cycle");

    // End of run, busy drops exactly as done shows up.
    busy_end: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) == done)
        else $error("busy fall and done pulse are not in the same cycle");

endmodule

bind top top_chk chk_i (
    .clk(clk),
    .rst_n(rst_n),
    .adc_cs(adc_cs),
    .adc_sclk(adc_sclk),
    .com_txd(com_txd),
    .busy(busy),
    .done(done)
);

/* flist.f */
verilog/acq_pkg.sv
verilog/sample_if.sv
verilog/console.sv
verilog/adc_spi.sv
verilog/data_make.sv
verilog/ram_data.sv
verilog/com_send.sv
verilog/top.sv
dv/top_chk.sv
dv/tb_top.sv

/* verilog/acq_pkg.sv */
package acq_pkg;

    // ------------------------------------------------------------
    // Channel and sample sizes.
    // ------------------------------------------------------------
    localparam int N_CH     = 4;
    localparam int CH_W     = $clog2(N_CH);
    localparam int SAMPLE_W = 12;

    // SPI transfer, one 16-bit frame with the sample in the low bits.
    localparam int SPI_BITS = 16;
    localparam int SPI_CW   = $clog2(SPI_BITS);
    localparam int SCLK_DIV = 4;
    localparam int SCLK_CW  = $clog2(SCLK_DIV);

    // Conversion request, same word to every ADC.
    localparam logic [SPI_BITS-1:0] ADC_CMD = 16'hd0a5;

    // Serial line, clk cycles per bit.
    localparam int BIT_DIV = 8;
    localparam int BIT_CW  = $clog2(BIT_DIV);

    // Frame layout.
    localparam logic [3:0] HDR_TAG = 4'ha;
    localparam int         ADDR_W  = 4;

    // ------------------------------------------------------------
    // State encodings.
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        CON_IDLE,
        CON_CONV,
        CON_SEND,
        CON_DONE
    } console_state_t;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_WAIT_FLOW,
        TX_READ,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

/* verilog/adc_spi.sv */
`timescale 1ns/1ps

module adc_spi import acq_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,

    input  logic            fs_conv,
    input  logic [N_CH-1:0] mask,

    input  logic [N_CH-1:0] adc_miso,
    output logic            adc_mosi,
    output logic            adc_sclk,
    output logic [N_CH-1:0] adc_cs,

    sample_if.src           smp
);

    logic                xfer;
    logic                emit;
    logic                gap;
    logic [SCLK_CW-1:0]  div;
    logic [SPI_CW-1:0]   bit_cnt;
    logic [SPI_BITS-1:0] tx_sr;
    logic [SPI_BITS-1:0] rx_sr [N_CH];
    logic [N_CH-1:0]     pend;
    logic [N_CH-1:0]     pend_next;
    logic [CH_W-1:0]     pick;
    logic                rise;
    logic                fall;

    // SCLK low for the first half period, high for the second.
    assign rise = xfer && (div == SCLK_CW'(SCLK_DIV / 2 - 1));
    assign fall = xfer && (div == SCLK_CW'(SCLK_DIV - 1));

    assign adc_mosi = tx_sr[SPI_BITS-1];

    // Lowest pending channel goes out first.
    always_comb begin
        pick = '0;
        for (int i = N_CH - 1; i >= 0; i--) begin
            if (pend[i]) begin
                pick = CH_W'(i);
            end
        end
        pend_next       = pend;
        pend_next[pick] = 1'b0;
    end

    // ------------------------------------------------------------
    // Transfer and sample stream control.
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xfer      <= 1'b0;
            emit      <= 1'b0;
            gap       <= 1'b0;
            div       <= '0;
            bit_cnt   <= '0;
            tx_sr     <= '0;
            pend      <= '0;
            adc_sclk  <= 1'b0;
            adc_cs    <= '1;
            smp.valid <= 1'b0;
            smp.last  <= 1'b0;
        end else begin
            smp.valid <= 1'b0;
            if (fs_conv && !xfer && !emit) begin
                // MSB of the command is on MOSI as CS falls.
                xfer    <= 1'b1;
                div     <= '0;
                bit_cnt <= '0;
                tx_sr   <= ADC_CMD;
                pend    <= mask;
                adc_cs  <= ~mask;
            end else if (xfer) begin
                div <= div + 1'b1;
                if (rise) begin
                    adc_sclk <= 1'b1;
                end
                if (fall) begin
                    adc_sclk <= 1'b0;
                    tx_sr    <= tx_sr << 1;
                    bit_cnt  <= bit_cnt + 1'b1;
                    if (bit_cnt == SPI_CW'(SPI_BITS - 1)) begin
                        xfer   <= 1'b0;
                        emit   <= 1'b1;
                        gap    <= 1'b0;
                        adc_cs <= '1;
                    end
                end
            end else if (emit) begin
                gap <= ~gap;
                if (!gap) begin
                    smp.valid <= 1'b1;
                    smp.last  <= (pend_next == '0);
                    pend      <= pend_next;
                    if (pend_next == '0) begin
                        emit <= 1'b0;
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Per channel receive shifters and sample payload.
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rise) begin
            for (int i = 0; i < N_CH; i++) begin
                rx_sr[i] <= {rx_sr[i][SPI_BITS-2:0], adc_miso[i]};
            end
        end
        if (emit && !gap) begin
            smp.chan <= pick;
            smp.data <= rx_sr[pick][SAMPLE_W-1:0];
        end
    end

endmodule

/* verilog/com_send.sv */
`timescale 1ns/1ps

module com_send import acq_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              fs_send,
    input  logic [ADDR_W-1:0] dlen,

    output logic [ADDR_W-1:0] ram_rxa,
    input  logic [7:0]        ram_rxd,

    input  logic              com_rxf,
    output logic              com_txd,
    output logic              com_txf,
    output logic              fd_send
);

    tx_state_t         state;
    logic [BIT_CW-1:0] bcnt;
    logic [2:0]        dbit;
    logic [ADDR_W-1:0] len;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        sh;
    logic              bit_end;

    assign bit_end = (bcnt == BIT_CW'(BIT_DIV - 1));
    assign ram_rxa = addr;
    assign com_txf = (state == TX_START) || (state == TX_DATA) || (state == TX_STOP);

    always_comb begin
        case (state)
            TX_START: com_txd = 1'b0;
            TX_DATA:  com_txd = sh[0];
            default:  com_txd = 1'b1;
        endcase
    end

    // ------------------------------------------------------------
    // Byte sequencer.
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= TX_IDLE;
            bcnt    <= '0;
            dbit    <= '0;
            len     <= '0;
            addr    <= '0;
            fd_send <= 1'b0;
        end else begin
            fd_send <= 1'b0;
            if (state == TX_START || state == TX_DATA || state == TX_STOP) begin
                bcnt <= bit_end ? '0 : bcnt + 1'b1;
            end
            case (state)
                TX_IDLE: begin
                    if (fs_send) begin
                        len   <= dlen;
                        addr  <= '0;
                        state <= TX_WAIT_FLOW;
                    end
                end
                TX_WAIT_FLOW: begin
                    // Host holds com_rxf high when it cannot take a byte.
                    if (!com_rxf) begin
                        state <= TX_READ;
                    end
                end
                TX_READ: begin
                    bcnt  <= '0;
                    state <= TX_START;
                end
                TX_START: begin
                    if (bit_end) begin
                        dbit  <= '0;
                        state <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        dbit <= dbit + 1'b1;
                        if (dbit == 3'd7) begin
                            state <= TX_STOP;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        if (addr == len - 1'b1) begin
                            fd_send <= 1'b1;
                            state   <= TX_IDLE;
                        end else begin
                            addr  <= addr + 1'b1;
                            state <= TX_WAIT_FLOW;
                        end
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    // Address was stable through WAIT_FLOW, so ram_rxd is current in READ.
    always_ff @(posedge clk) begin
        if (state == TX_READ) begin
            sh <= ram_rxd;
        end else if (state == TX_DATA && bit_end) begin
            sh <= sh >> 1;
        end
    end

endmodule

/* verilog/console.sv */
`timescale 1ns/1ps

module console import acq_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              start,
    input  logic [N_CH-1:0]   chan_mask,
    output logic              busy,
    output logic              done,

    output logic              fs_conv,
    output logic              fs_tran,
    output logic [N_CH-1:0]   mask,
    input  logic              fd_tran,

    output logic              fs_send,
    output logic [ADDR_W-1:0] dlen,
    input  logic              fd_send
);

    console_state_t state;

    // Header byte plus two bytes per enabled channel.
    function automatic logic [ADDR_W-1:0] frame_len(input logic [N_CH-1:0] m);
        logic [ADDR_W-1:0] n;
        n = ADDR_W'(1);
        for (int i = 0; i < N_CH; i++) begin
            if (m[i]) begin
                n = n + ADDR_W'(2);
            end
        end
        return n;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= CON_IDLE;
            fs_conv <= 1'b0;
            fs_tran <= 1'b0;
            fs_send <= 1'b0;
            mask    <= '0;
            dlen    <= '0;
        end else begin
            fs_conv <= 1'b0;
            fs_tran <= 1'b0;
            fs_send <= 1'b0;
            case (state)
                CON_IDLE: begin
                    if (start && |chan_mask) begin
                        state   <= CON_CONV;
                        fs_conv <= 1'b1;
                        fs_tran <= 1'b1;
                        mask    <= chan_mask;
                        dlen    <= frame_len(chan_mask);
                    end
                end
                CON_CONV: begin
                    // Frame is complete in RAM.
                    if (fd_tran) begin
                        state   <= CON_SEND;
                        fs_send <= 1'b1;
                    end
                end
                CON_SEND: begin
                    if (fd_send) begin
                        state <= CON_DONE;
                    end
                end
                default: begin
                    state <= CON_IDLE;
                end
            endcase
        end
    end

    // Done holds for the single DONE cycle, busy is already low there.
    assign busy = (state == CON_CONV) || (state == CON_SEND);
    assign done = (state == CON_DONE);

endmodule

/* verilog/data_make.sv */
`timescale 1ns/1ps

module data_make import acq_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              fs_tran,
    input  logic [N_CH-1:0]   mask,
    sample_if.dst             smp,

    output logic [ADDR_W-1:0] ram_txa,
    output logic [7:0]        ram_txd,
    output logic              ram_txen,
    output logic              fd_tran
);

    logic [ADDR_W-1:0] waddr;
    logic              second;
    logic              last_q;
    logic              fin;
    logic [7:0]        lo_byte;

    // Write enable and sequencing.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            waddr    <= '0;
            second   <= 1'b0;
            last_q   <= 1'b0;
            fin      <= 1'b0;
            ram_txen <= 1'b0;
            fd_tran  <= 1'b0;
        end else begin
            ram_txen <= 1'b0;
            fd_tran  <= fin;
            fin      <= 1'b0;
            if (fs_tran) begin
                ram_txen <= 1'b1;
                waddr    <= ADDR_W'(1);
            end else if (smp.valid) begin
                ram_txen <= 1'b1;
                waddr    <= waddr + 1'b1;
                second   <= 1'b1;
                last_q   <= smp.last;
            end else if (second) begin
                // Valid never repeats here, so the low byte has the slot.
                ram_txen <= 1'b1;
                waddr    <= waddr + 1'b1;
                second   <= 1'b0;
                fin      <= last_q;
            end
        end
    end

    // Address and byte data.
    always_ff @(posedge clk) begin
        if (fs_tran) begin
            ram_txa <= '0;
            ram_txd <= {HDR_TAG, mask};
        end else if (smp.valid) begin
            ram_txa <= waddr;
            ram_txd <= {smp.chan, 2'b00, smp.data[SAMPLE_W-1:8]};
            lo_byte <= smp.data[7:0];
        end else if (second) begin
            ram_txa <= waddr;
            ram_txd <= lo_byte;
        end
    end

endmodule

/* verilog/ram_data.sv */
`timescale 1ns/1ps

module ram_data import acq_pkg::*; (
    input  logic              clk,

    input  logic [ADDR_W-1:0] ram_txa,
    input  logic [7:0]        ram_txd,
    input  logic              ram_txen,

    input  logic [ADDR_W-1:0] ram_rxa,
    output logic [7:0]        ram_rxd
);

    logic [7:0] mem [2**ADDR_W];

    // Write port A, registered read port B.
    always_ff @(posedge clk) begin
        if (ram_txen) begin
            mem[ram_txa] <= ram_txd;
        end
        ram_rxd <= mem[ram_rxa];
    end

endmodule

/* verilog/sample_if.sv */
`timescale 1ns/1ps

interface sample_if import acq_pkg::*; ();

    // One sample per strobe, never on back to back cycles.
    logic                valid;
    logic [CH_W-1:0]     chan;
    logic [SAMPLE_W-1:0] data;
    logic                last;

    modport src (
        output valid, chan, data, last
    );

    modport dst (
        input valid, chan, data, last
    );

endinterface

/* verilog/top.sv */
`timescale 1ns/1ps

module top import acq_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,

    input  logic            start,
    input  logic [N_CH-1:0] chan_mask,

    input  logic [N_CH-1:0] adc_miso,
    output logic            adc_mosi,
    output logic            adc_sclk,
    output logic [N_CH-1:0] adc_cs,

    input  logic            com_rxf,
    output logic            com_txd,
    output logic            com_txf,

    output logic            busy,
    output logic            done
);

    // Control strobes.
    logic fs_conv;
    logic fs_tran, fd_tran;
    logic fs_send, fd_send;

    logic [N_CH-1:0]   mask;
    logic [ADDR_W-1:0] dlen;

    // RAM ports.
    logic [ADDR_W-1:0] ram_txa, ram_rxa;
    logic [7:0]        ram_txd, ram_rxd;
    logic              ram_txen;

    sample_if smp_if ();

    console
    console_dut(
        .clk(clk),
        .rst_n(rst_n),
        .start(start),
        .chan_mask(chan_mask),
        .busy(busy),
        .done(done),
        .fs_conv(fs_conv),
        .fs_tran(fs_tran),
        .mask(mask),
        .fd_tran(fd_tran),
        .fs_send(fs_send),
        .dlen(dlen),
        .fd_send(fd_send)
    );

    adc_spi
    adc_spi_dut(
        .clk(clk),
        .rst_n(rst_n),
        .fs_conv(fs_conv),
        .mask(mask),
        .adc_miso(adc_miso),
        .adc_mosi(adc_mosi),
        .adc_sclk(adc_sclk),
        .adc_cs(adc_cs),
        .smp(smp_if.src)
    );

    data_make
    data_make_dut(
        .clk(clk),
        .rst_n(rst_n),
        .fs_tran(fs_tran),
        .mask(mask),
        .smp(smp_if.dst),
        .ram_txa(ram_txa),
        .ram_txd(ram_txd),
        .ram_txen(ram_txen),
        .fd_tran(fd_tran)
    );

    ram_data
    ram_data_dut(
        .clk(clk),
        .ram_txa(ram_txa),
        .ram_txd(ram_txd),
        .ram_txen(ram_txen),
        .ram_rxa(ram_rxa),
        .ram_rxd(ram_rxd)
    );

    com_send
    com_send_dut(
        .clk(clk),
        .rst_n(rst_n),
        .fs_send(fs_send),
        .dlen(dlen),
        .ram_rxa(ram_rxa),
        .ram_rxd(ram_rxd),
        .com_rxf(com_rxf),
        .com_txd(com_txd),
        .com_txf(com_txf),
        .fd_send(fd_send)
    );

endmodule
